// ==== source/dot_accumulator.sv ====
`timescale 1ns/1ps

module dot_accumulator #(
	parameter int VECTOR_LEN        = vector_mac_pkg::DEF_VECTOR_LEN,
	parameter int A_CELL_WIDTH      = vector_mac_pkg::DEF_A_CELL_WIDTH,
	parameter int B_CELL_WIDTH      = vector_mac_pkg::DEF_B_CELL_WIDTH,
	parameter int RESULT_CELL_WIDTH = vector_mac_pkg::DEF_RESULT_CELL_WIDTH
) (
	input  logic                         clk,
	input  logic                         arst_n,
	tile_if.acc_mp                       part,
	output logic [RESULT_CELL_WIDTH-1:0] result,
	output logic                         valid,
	output logic                         error
);

	// Wide enough for the full dot product, no wrap
	localparam int ACC_WIDTH = A_CELL_WIDTH + B_CELL_WIDTH + $clog2(VECTOR_LEN);

	// Signed result range, at accumulator width
	localparam logic signed [ACC_WIDTH-1:0] RES_MAX =
		ACC_WIDTH'((2 ** (RESULT_CELL_WIDTH - 1)) - 1);
	localparam logic signed [ACC_WIDTH-1:0] RES_MIN =
		-ACC_WIDTH'(2 ** (RESULT_CELL_WIDTH - 1));

	logic signed [ACC_WIDTH-1:0]  acc;
	logic signed [ACC_WIDTH-1:0]  total;
	logic                         sat_hi;
	logic                         sat_lo;
	logic [RESULT_CELL_WIDTH-1:0] clipped;

	////////////////////////////////////////
	// Running sum
	////////////////////////////////////////

	// First tile restarts the sum
	assign total = part.psum_first ? part.psum : (acc + part.psum);

	always_ff @(posedge clk) begin
		if (part.psum_valid) begin
			acc <= total;
		end
	end

	////////////////////////////////////////
	// Saturation
	////////////////////////////////////////

	assign sat_hi = (total > RES_MAX);
	assign sat_lo = (total < RES_MIN);

	always_comb begin
		if (sat_hi) begin
			clipped = RES_MAX[RESULT_CELL_WIDTH-1:0];
		end else if (sat_lo) begin
			clipped = RES_MIN[RESULT_CELL_WIDTH-1:0];
		end else begin
			// In range, upper bits are pure sign
			clipped = total[RESULT_CELL_WIDTH-1:0];
		end
	end

	// Result held until the next vector completes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
			valid  <= 1'b0;
			error  <= 1'b0;
		end else begin
			valid <= part.psum_valid && part.psum_last;
			error <= part.psum_valid && part.psum_last && (sat_hi || sat_lo);
			if (part.psum_valid && part.psum_last) begin
				result <= clipped;
			end
		end
	end

endmodule

// ==== source/operand_slicer.sv ====
`timescale 1ns/1ps

module operand_slicer #(
	parameter int VECTOR_LEN   = vector_mac_pkg::DEF_VECTOR_LEN,
	parameter int A_CELL_WIDTH = vector_mac_pkg::DEF_A_CELL_WIDTH,
	parameter int B_CELL_WIDTH = vector_mac_pkg::DEF_B_CELL_WIDTH,
	parameter int TILING       = vector_mac_pkg::DEF_TILING
) (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               start,
	input  logic [VECTOR_LEN*A_CELL_WIDTH-1:0] a,
	input  logic [VECTOR_LEN*B_CELL_WIDTH-1:0] b,
	tile_if.slicer_mp                          tile
);

	import vector_mac_pkg::*;

	////////////////////////////////////////
	// Geometry
	////////////////////////////////////////

	localparam int NUM_TILES = (VECTOR_LEN + TILING - 1) / TILING;
	localparam int CNT_WIDTH = (NUM_TILES > 1) ? $clog2(NUM_TILES) : 1;

	// Operands padded up to a whole number of tiles
	localparam int PAD_LEN      = NUM_TILES * TILING;
	localparam int A_PAD_WIDTH  = PAD_LEN * A_CELL_WIDTH;
	localparam int B_PAD_WIDTH  = PAD_LEN * B_CELL_WIDTH;
	localparam int TILE_A_WIDTH = TILING * A_CELL_WIDTH;
	localparam int TILE_B_WIDTH = TILING * B_CELL_WIDTH;

	slicer_state_e        state;
	logic [CNT_WIDTH-1:0] tile_cnt;
	logic                 last_cnt;
	logic                 accept;

	logic [A_PAD_WIDTH-1:0] a_pad;
	logic [B_PAD_WIDTH-1:0] b_pad;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	assign last_cnt = (tile_cnt == CNT_WIDTH'(NUM_TILES - 1));

	// Start also taken while the final tile goes out
	// so vectors can follow each other without a gap
	assign accept = start && ((state == idle) || last_cnt);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= idle;
			tile_cnt <= '0;
		end else if (accept) begin
			state    <= issue;
			tile_cnt <= '0;
		end else if (state == issue) begin
			if (last_cnt) begin
				state    <= idle;
				tile_cnt <= '0;
			end else begin
				tile_cnt <= tile_cnt + 1'b1;
			end
		end
	end

	// Qualifier strobes for the current tile
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tile.tile_valid <= 1'b0;
			tile.tile_first <= 1'b0;
			tile.tile_last  <= 1'b0;
		end else begin
			tile.tile_valid <= (state == issue);
			tile.tile_first <= (state == issue) && (tile_cnt == '0);
			tile.tile_last  <= (state == issue) && last_cnt;
		end
	end

	////////////////////////////////////////
	// Operand data
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		// Zero extension fills the unused slots of the last tile
		if (accept) begin
			a_pad <= A_PAD_WIDTH'(a);
			b_pad <= B_PAD_WIDTH'(b);
		end
		// Old operands still read here when a new start lands
		if (state == issue) begin
			tile.tile_a <= a_pad[tile_cnt*TILE_A_WIDTH +: TILE_A_WIDTH];
			tile.tile_b <= b_pad[tile_cnt*TILE_B_WIDTH +: TILE_B_WIDTH];
		end
	end

endmodule

// ==== source/tile_if.sv ====
`timescale 1ns/1ps

interface tile_if #(
	parameter int VECTOR_LEN   = vector_mac_pkg::DEF_VECTOR_LEN,
	parameter int TILING       = vector_mac_pkg::DEF_TILING,
	parameter int A_CELL_WIDTH = vector_mac_pkg::DEF_A_CELL_WIDTH,
	parameter int B_CELL_WIDTH = vector_mac_pkg::DEF_B_CELL_WIDTH
);

	// Partial sums are carried at full accumulator width
	localparam int ACC_WIDTH = A_CELL_WIDTH + B_CELL_WIDTH + $clog2(VECTOR_LEN);

	// Operand group, slicer to multiplier bank
	logic                                     tile_valid;
	logic [TILING-1:0][A_CELL_WIDTH-1:0]      tile_a;
	logic [TILING-1:0][B_CELL_WIDTH-1:0]      tile_b;
	logic                                     tile_first;
	logic                                     tile_last;

	// Partial group, multiplier bank to accumulator
	logic                                     psum_valid;
	logic signed [ACC_WIDTH-1:0]              psum;
	logic                                     psum_first;
	logic                                     psum_last;

	modport slicer_mp (output tile_valid, tile_a, tile_b, tile_first, tile_last);

	modport mult_in_mp (input tile_valid, tile_a, tile_b, tile_first, tile_last);

	modport mult_out_mp (output psum_valid, psum, psum_first, psum_last);

	modport acc_mp (input psum_valid, psum, psum_first, psum_last);

endinterface

// ==== source/tile_multiplier.sv ====
`timescale 1ns/1ps

module tile_multiplier #(
	parameter int VECTOR_LEN   = vector_mac_pkg::DEF_VECTOR_LEN,
	parameter int A_CELL_WIDTH = vector_mac_pkg::DEF_A_CELL_WIDTH,
	parameter int B_CELL_WIDTH = vector_mac_pkg::DEF_B_CELL_WIDTH,
	parameter int TILING       = vector_mac_pkg::DEF_TILING
) (
	input  logic        clk,
	input  logic        arst_n,
	tile_if.mult_in_mp  tile_in,
	tile_if.mult_out_mp tile_out
);

	localparam int ACC_WIDTH = A_CELL_WIDTH + B_CELL_WIDTH + $clog2(VECTOR_LEN);

	// Tree leaves, rounded up to a power of two
	localparam int LEAVES = 1 << $clog2(TILING);

	// Heap layout
	// Root at 0, children of i at 2i+1 and 2i+2
	logic signed [ACC_WIDTH-1:0] node [2*LEAVES-1];

	////////////////////////////////////////
	// Multipliers
	////////////////////////////////////////

	genvar g;
	generate
		for (g = 0; g < LEAVES; g++) begin : g_leaf
			if (g < TILING) begin : g_mul
				// Operands sign extend to accumulator width first
				assign node[LEAVES-1+g] = $signed(tile_in.tile_a[g]) *
					$signed(tile_in.tile_b[g]);
			end else begin : g_pad
				// Unused leaf
				assign node[LEAVES-1+g] = '0;
			end
		end

		////////////////////////////////////////
		// Balanced adder tree
		////////////////////////////////////////

		for (g = 0; g < LEAVES - 1; g++) begin : g_add
			assign node[g] = node[2*g+1] + node[2*g+2];
		end
	endgenerate

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	// One tile per cycle, no stall
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tile_out.psum_valid <= 1'b0;
			tile_out.psum_first <= 1'b0;
			tile_out.psum_last  <= 1'b0;
		end else begin
			tile_out.psum_valid <= tile_in.tile_valid;
			tile_out.psum_first <= tile_in.tile_valid && tile_in.tile_first;
			tile_out.psum_last  <= tile_in.tile_valid && tile_in.tile_last;
		end
	end

	always_ff @(posedge clk) begin
		if (tile_in.tile_valid) begin
			tile_out.psum <= node[0];
		end
	end

endmodule

// ==== source/vector_mac.sv ====
`timescale 1ns/1ps

module vector_mac #(
	parameter int VECTOR_LEN        = vector_mac_pkg::DEF_VECTOR_LEN,
	parameter int A_CELL_WIDTH      = vector_mac_pkg::DEF_A_CELL_WIDTH,
	parameter int B_CELL_WIDTH      = vector_mac_pkg::DEF_B_CELL_WIDTH,
	parameter int RESULT_CELL_WIDTH = vector_mac_pkg::DEF_RESULT_CELL_WIDTH,
	parameter int TILING            = vector_mac_pkg::DEF_TILING
) (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               start,
	input  logic [VECTOR_LEN*A_CELL_WIDTH-1:0] a,
	input  logic [VECTOR_LEN*B_CELL_WIDTH-1:0] b,
	output logic [RESULT_CELL_WIDTH-1:0]       result,
	output logic                               valid,
	output logic                               error
);

	////////////////////////////////////////
	// Internal tile bus
	////////////////////////////////////////

	tile_if #(
		.VECTOR_LEN  (VECTOR_LEN),
		.TILING      (TILING),
		.A_CELL_WIDTH(A_CELL_WIDTH),
		.B_CELL_WIDTH(B_CELL_WIDTH)
	) tile_bus ();

	// Captures operands and steps through tiles
	operand_slicer #(
		.VECTOR_LEN  (VECTOR_LEN),
		.A_CELL_WIDTH(A_CELL_WIDTH),
		.B_CELL_WIDTH(B_CELL_WIDTH),
		.TILING      (TILING)
	) operand_slicer_i (
		.clk   (clk),
		.arst_n(arst_n),
		.start (start),
		.a     (a),
		.b     (b),
		.tile  (tile_bus)
	);

	// One partial sum per tile
	tile_multiplier #(
		.VECTOR_LEN  (VECTOR_LEN),
		.A_CELL_WIDTH(A_CELL_WIDTH),
		.B_CELL_WIDTH(B_CELL_WIDTH),
		.TILING      (TILING)
	) tile_multiplier_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.tile_in (tile_bus),
		.tile_out(tile_bus)
	);

	// Sum, clip, strobe
	dot_accumulator #(
		.VECTOR_LEN       (VECTOR_LEN),
		.A_CELL_WIDTH     (A_CELL_WIDTH),
		.B_CELL_WIDTH     (B_CELL_WIDTH),
		.RESULT_CELL_WIDTH(RESULT_CELL_WIDTH)
	) dot_accumulator_i (
		.clk   (clk),
		.arst_n(arst_n),
		.part  (tile_bus),
		.result(result),
		.valid (valid),
		.error (error)
	);

endmodule

// ==== source/vector_mac_pkg.sv ====
package vector_mac_pkg;

	////////////////////////////////////////
	// Controller state
	////////////////////////////////////////

	// Slicer is either waiting for start or stepping through tiles
	typedef enum logic {
		idle,
		issue
	} slicer_state_e;

	////////////////////////////////////////
	// Default geometry
	////////////////////////////////////////

	// Elements per operand vector
	parameter int DEF_VECTOR_LEN = 5;

	// Element width of vector a
	parameter int DEF_A_CELL_WIDTH = 8;

	// Element width of vector b
	parameter int DEF_B_CELL_WIDTH = 8;

	// Saturated result width, signed
	parameter int DEF_RESULT_CELL_WIDTH = 10;

	// Multipliers working in parallel
	// One tile of this many element pairs per cycle
	parameter int DEF_TILING = 2;

	// With these defaults
	// 3 tiles per vector, last tile half empty
	// 19 bit accumulator, 5 cycle latency

endpackage

// ==== testbench/tb_vector_mac_table.svh ====
	////////////////////////////////////////
	// Directed stimulus table
	////////////////////////////////////////

	// One row per line, element 0 first in each vector
	// Columns are a elements, b elements, cycles to next start, expected result, expected error
	// A gap equal to NUM_TILES puts the next start right behind the last tile

	task automatic load_table();
		// Reference vector, plain in-range sum
		add_row(pack_a(1, 2, 3, 4, 5), pack_b(8, 6, 7, 8, 20), 8, 173, 1'b0);
		// Reference vector, -200 keeps only its low byte 56
		add_row(pack_a(-200, 100, 50, 20, 10), pack_b(10, 5, 3, 2, 1), 8, 511, 1'b1);

		// Back to back from here on
		add_row(pack_a(0, 0, 0, 0, 0), pack_b(-128, 127, -1, 5, 9), 3, 0, 1'b0);
		add_row(pack_a(-1, -2, -3, -4, -5), pack_b(1, 2, 3, 4, 5), 3, -55, 1'b0);

		// Extreme operands, clipped both ways
		add_row(pack_a(127, 127, 127, 127, 127), pack_b(-128, -128, -128, -128, -128),
			3, -512, 1'b1);
		add_row(pack_a(127, 127, 127, 127, 127), pack_b(127, 127, 127, 127, 127),
			3, 511, 1'b1);
		add_row(pack_a(-128, -128, -128, -128, -128), pack_b(-128, -128, -128, -128, -128),
			3, 511, 1'b1);

		// Upper edge of the range
		add_row(pack_a(100, 1, 0, 0, 0), pack_b(5, 11, 0, 0, 0), 4, 511, 1'b0);
		add_row(pack_a(100, 1, 0, 0, 0), pack_b(5, 12, 0, 0, 0), 3, 511, 1'b1);

		// Lower edge
		add_row(pack_a(-128, 0, 0, 0, 0), pack_b(4, 0, 0, 0, 0), 5, -512, 1'b0);
		add_row(pack_a(-128, -1, 0, 0, 0), pack_b(4, 1, 0, 0, 0), 3, -512, 1'b1);

		// Lone element in the half empty last tile
		add_row(pack_a(0, 0, 0, 0, -7), pack_b(0, 0, 0, 0, 9), 6, -63, 1'b0);
		// Lone element in the upper half of tile 0
		add_row(pack_a(0, 9, 0, 0, 0), pack_b(0, -9, 0, 0, 0), 3, -81, 1'b0);

		// Mixed signs, in range
		add_row(pack_a(3, -4, 5, -6, 7), pack_b(-8, 9, -10, 11, -12), 3, -260, 1'b0);
		add_row(pack_a(0, 0, 20, 0, 0), pack_b(0, 0, 25, 0, 0), 7, 500, 1'b0);

		// Large partial sums that cancel inside the first tile
		add_row(pack_a(127, 127, 0, 0, 0), pack_b(127, -127, 0, 0, 0), 3, 0, 1'b0);
		// Cancellation across tiles, still too large
		add_row(pack_a(100, 100, 100, -100, -100), pack_b(50, 50, 50, 50, 50),
			3, 511, 1'b1);
	endtask

// ==== testbench/tb_vector_mac.sv ====
`timescale 1ns/1ps

module tb_vector_mac;

	import vector_mac_pkg::*;

	localparam int VL = DEF_VECTOR_LEN;
	localparam int AW = DEF_A_CELL_WIDTH;
	localparam int BW = DEF_B_CELL_WIDTH;
	localparam int RW = DEF_RESULT_CELL_WIDTH;
	localparam int TL = DEF_TILING;

	// Tiles per vector and cycles from start to valid
	localparam int NUM_TILES   = (VL + TL - 1) / TL;
	localparam int LATENCY     = NUM_TILES + 2;
	localparam int RANDOM_ROWS = 40;

	// Signed result range
	localparam int RES_MAX = (2 ** (RW - 1)) - 1;
	localparam int RES_MIN = -(2 ** (RW - 1));

	typedef struct packed {
		logic [VL*AW-1:0] a;
		logic [VL*BW-1:0] b;
		int               gap;
		int               exp_result;
		logic             exp_error;
	} row_t;

	// Scoreboard entry with the cycle count where valid must show
	typedef struct packed {
		logic [RW-1:0] result;
		logic          error;
		int            due;
	} expect_t;

	logic             clk;
	logic             arst_n;
	logic             start;
	logic [VL*AW-1:0] a;
	logic [VL*BW-1:0] b;
	logic [RW-1:0]    result;
	logic             valid;
	logic             error;

	row_t    rows[$];
	expect_t pending[$];
	int      cycle;
	int      limit;
	int      max_gap;

	vector_mac #(
		.VECTOR_LEN       (VL),
		.A_CELL_WIDTH     (AW),
		.B_CELL_WIDTH     (BW),
		.RESULT_CELL_WIDTH(RW),
		.TILING           (TL)
	) vector_mac_i (
		.clk   (clk),
		.arst_n(arst_n),
		.start (start),
		.a     (a),
		.b     (b),
		.result(result),
		.valid (valid),
		.error (error)
	);

	// 20 ns period
	always #10 clk = ~clk;

	////////////////////////////////////////
	// Failure reporting and compares
	////////////////////////////////////////

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_result(input logic [RW-1:0] got, input logic [RW-1:0] exp,
		input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what,
				$signed(got), $signed(exp));
			abort_run();
		end
	endtask

	task automatic check_error(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_latency(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("[FAIL] %0t: %s at cycle %0d, expected cycle %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// Row building and reference model
	////////////////////////////////////////

	// Elements given in index order and each cut to the cell width
	function automatic logic [VL*AW-1:0] pack_a(input int e0, e1, e2, e3, e4);
		logic [VL*AW-1:0] v;
		v = {AW'(e4), AW'(e3), AW'(e2), AW'(e1), AW'(e0)};
		return v;
	endfunction

	function automatic logic [VL*BW-1:0] pack_b(input int e0, e1, e2, e3, e4);
		logic [VL*BW-1:0] v;
		v = {BW'(e4), BW'(e3), BW'(e2), BW'(e1), BW'(e0)};
		return v;
	endfunction

	task automatic add_row(input logic [VL*AW-1:0] va, input logic [VL*BW-1:0] vb,
		input int gap, input int exp_result, input logic exp_error);
		row_t r;
		r.a          = va;
		r.b          = vb;
		r.gap        = gap;
		r.exp_result = exp_result;
		r.exp_error  = exp_error;
		rows.push_back(r);
	endtask

	// Exact signed sum of products clamped to the result range
	function automatic row_t model_row(input logic [VL*AW-1:0] va,
		input logic [VL*BW-1:0] vb, input int gap);
		row_t r;
		int   sum;
		int   ea;
		int   eb;
		int   i;
		sum = 0;
		for (i = 0; i < VL; i++) begin
			ea  = $signed(va[i*AW +: AW]);
			eb  = $signed(vb[i*BW +: BW]);
			sum = sum + ea * eb;
		end
		r.a         = va;
		r.b         = vb;
		r.gap       = gap;
		r.exp_error = (sum > RES_MAX) || (sum < RES_MIN);
		if (sum > RES_MAX) begin
			r.exp_result = RES_MAX;
		end else if (sum < RES_MIN) begin
			r.exp_result = RES_MIN;
		end else begin
			r.exp_result = sum;
		end
		return r;
	endfunction

	`include "tb_vector_mac_table.svh"

	task automatic add_random_rows();
		logic [VL*AW-1:0] va;
		logic [VL*BW-1:0] vb;
		int               i;
		int               j;
		for (i = 0; i < RANDOM_ROWS; i++) begin
			for (j = 0; j < VL; j++) begin
				if (i % 2 == 0) begin
					// small magnitudes keep many sums in range
					va[j*AW +: AW] = AW'(int'($urandom_range(31)) - 16);
					vb[j*BW +: BW] = BW'(int'($urandom_range(31)) - 16);
				end else begin
					va[j*AW +: AW] = AW'($urandom);
					vb[j*BW +: BW] = BW'($urandom);
				end
			end
			rows.push_back(model_row(va, vb, NUM_TILES + int'($urandom_range(3))));
		end
	endtask

	////////////////////////////////////////
	// Drivers called on a falling edge
	////////////////////////////////////////

	task automatic apply_row(input row_t r);
		expect_t e;
		start    = 1'b1;
		a        = r.a;
		b        = r.b;
		e.result = RW'(r.exp_result);
		e.error  = r.exp_error;
		e.due    = cycle + 1 + LATENCY;
		pending.push_back(e);
		@(negedge clk);
		start = 1'b0;
		repeat (r.gap - 1) @(negedge clk);
	endtask

	// Start stays high while the kept vector is still being issued
	task automatic apply_with_stray_start(input row_t kept, input row_t dropped);
		expect_t e;
		start    = 1'b1;
		a        = kept.a;
		b        = kept.b;
		e.result = RW'(kept.exp_result);
		e.error  = kept.exp_error;
		e.due    = cycle + 1 + LATENCY;
		pending.push_back(e);
		@(negedge clk);
		a = dropped.a;
		b = dropped.b;
		repeat (NUM_TILES - 1) @(negedge clk);
		// Low again before the edge that could accept it
		start = 1'b0;
		repeat (kept.gap - NUM_TILES) @(negedge clk);
	endtask

	////////////////////////////////////////
	// Cycle count, timeout, output monitor
	////////////////////////////////////////

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			abort_run();
		end
	end

	always @(negedge clk) begin : watch_outputs
		expect_t e;
		if (arst_n) begin
			if (valid) begin
				if (pending.size() == 0) begin
					$display("valid pulsed at %0t with no accepted start waiting", $time);
					abort_run();
				end else begin
					e = pending.pop_front();
					check_latency(cycle, e.due, "valid");
					check_result(result, e.result, "result");
					check_error(error, e.error, "error flag");
				end
			end else begin
				check_error(error, 1'b0, "error flag without valid");
			end
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		row_t kept;
		row_t dropped;
		int   i;
		clk    = 1'b0;
		arst_n = 1'b0;
		start  = 1'b0;
		a      = '0;
		b      = '0;
		cycle  = 0;
		void'($urandom(55334));
		load_table();
		add_random_rows();
		kept    = model_row(pack_a(2, 3, 4, 5, 6), pack_b(1, 1, 1, 1, 1), 8);
		dropped = model_row(pack_a(10, 10, 10, 10, 10), pack_b(10, 10, 10, 10, 10), 8);

		// Worst case per row plus the stray start row
		max_gap = kept.gap;
		for (i = 0; i < rows.size(); i++) begin
			if (rows[i].gap > max_gap) begin
				max_gap = rows[i].gap;
			end
		end
		limit = (rows.size() + 1) * (LATENCY + max_gap) + 100;

		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		check_result(result, '0, "result after reset");
		check_error(valid, 1'b0, "valid after reset");
		check_error(error, 1'b0, "error after reset");
		repeat (4) @(negedge clk);

		for (i = 0; i < rows.size(); i++) begin
			apply_row(rows[i]);
		end
		apply_with_stray_start(kept, dropped);

		// Last result is due within a fixed latency
		repeat (LATENCY + 2) @(negedge clk);
		if (pending.size() != 0) begin
			$display("%0d expected results never appeared", pending.size());
			abort_run();
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== vector_mac.f ====
+incdir+testbench
source/vector_mac_pkg.sv
source/tile_if.sv
source/operand_slicer.sv
source/tile_multiplier.sv
source/dot_accumulator.sv
source/vector_mac.sv
testbench/tb_vector_mac.sv
